// File: rtl/coherence_config.svh
//////////////////////////////////////////////////////////////////////
// Coherence directory configuration
// Sizes shared by the RTL and the testbench
//////////////////////////////////////////////////////////////////////
`ifndef COHERENCE_CONFIG_SVH
`define COHERENCE_CONFIG_SVH

`define COH_NUM_L2        4
`define COH_NUM_SETS      16
`define COH_NUM_WAYS      4
`define COH_WAY_WIDTH     2
`define COH_ADDR_WIDTH    32
`define COH_OFFSET_WIDTH  6     // Block offset below the set index
`define COH_INDEX_WIDTH   4
`define COH_DATA_WIDTH    32
`define COH_PORT_WIDTH    2

`endif

// File: rtl/coherence_pkg.sv
//////////////////////////////////////////////////////////////////////
// Coherence package
// MESI, operation and sequencer enums, plus the request and line structs
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "coherence_config.svh"

package coherence_pkg;

    typedef enum logic [1:0] {
        MESI_INVALID   = 2'b00,
        MESI_SHARED    = 2'b01,
        MESI_EXCLUSIVE = 2'b10,
        MESI_MODIFIED  = 2'b11
    } mesi_state_t;

    typedef enum logic {
        OP_READ_UPDATE,
        OP_WRITE_UPDATE
    } coh_op_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOOKUP,
        SEQ_RESPOND,
        SEQ_RELEASE
    } seq_state_t;

    // Request levels held by an L2 port until verify
    typedef struct packed {
        logic                        read_update;
        logic                        write_update;
        logic [`COH_ADDR_WIDTH-1:0]  addr;
        logic [`COH_WAY_WIDTH-1:0]   way;
        logic [`COH_DATA_WIDTH-1:0]  data;
    } l2_req_t;

    typedef struct packed {
        logic        verify;
        mesi_state_t mesi_state;
    } l2_rsp_t;

    typedef struct packed {
        logic                        valid;
        coh_op_t                     op;
        logic [`COH_PORT_WIDTH-1:0]  port;
        logic [`COH_INDEX_WIDTH-1:0] set;
        logic [`COH_WAY_WIDTH-1:0]   way;
    } line_op_t;

    typedef struct packed {
        logic                        valid;
        logic [`COH_PORT_WIDTH-1:0]  port;
        logic [`COH_INDEX_WIDTH-1:0] set;
        logic [`COH_WAY_WIDTH-1:0]   way;
        logic [`COH_DATA_WIDTH-1:0]  data;
    } shadow_wr_t;

endpackage

`default_nettype wire

// File: rtl/coherence_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Coherence sequencer
// Fixed priority pick of one L2 request at a time, transaction FSM
// and the per-port verify and state responses
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "coherence_config.svh"

module coherence_sequencer import coherence_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  l2_req_t [`COH_NUM_L2-1:0]  l2_req,
    input  mesi_state_t                new_state,
    output l2_rsp_t [`COH_NUM_L2-1:0]  l2_rsp,
    output shadow_wr_t                 shadow_wr,
    output line_op_t                   line_op
);

    seq_state_t                  state_q;
    seq_state_t                  state_d;
    mesi_state_t                 rsp_state_q;
    logic [`COH_NUM_L2-1:0]      req_any;
    logic [`COH_NUM_L2-1:0]      req_both;
    logic [`COH_NUM_L2-1:0]      verify_vec;
    logic                        pick_valid;
    logic [`COH_PORT_WIDTH-1:0]  pick_port;
    l2_req_t                     pick_req;
    logic [`COH_INDEX_WIDTH-1:0] pick_set;

    always_comb begin
        for (int i = 0; i < `COH_NUM_L2; i++) begin
            req_any[i]  = l2_req[i].read_update | l2_req[i].write_update;
            req_both[i] = l2_req[i].read_update & l2_req[i].write_update;
        end
    end

    // Scan downwards so the lowest requesting port is left in pick_port
    always_comb begin
        pick_valid = 1'b0;
        pick_port  = '0;
        for (int i = `COH_NUM_L2-1; i >= 0; i--) begin
            if (req_any[i]) begin
                pick_valid = 1'b1;
                pick_port  = `COH_PORT_WIDTH'(i);
            end
        end
    end

    assign pick_req = l2_req[pick_port];
    assign pick_set = pick_req.addr[`COH_OFFSET_WIDTH +: `COH_INDEX_WIDTH];

    // Snapshot is written on the acceptance edge itself
    always_comb begin
        shadow_wr.valid = (state_q == SEQ_IDLE) && pick_valid;
        shadow_wr.port  = pick_port;
        shadow_wr.set   = pick_set;
        shadow_wr.way   = pick_req.way;
        shadow_wr.data  = pick_req.data;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE: begin
                if (pick_valid) begin
                    state_d = SEQ_LOOKUP;
                end
            end
            SEQ_LOOKUP:  state_d = SEQ_RESPOND;    // Directory updates on this edge
            SEQ_RESPOND: state_d = SEQ_RELEASE;
            SEQ_RELEASE: begin
                if (!req_any[line_op.port]) begin
                    state_d = SEQ_IDLE;
                end
            end
            default: state_d = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q     <= SEQ_IDLE;
            line_op     <= '0;
            rsp_state_q <= MESI_INVALID;
        end else begin
            state_q <= state_d;
            if (shadow_wr.valid) begin
                line_op.valid <= 1'b1;
                line_op.op    <= pick_req.write_update ? OP_WRITE_UPDATE : OP_READ_UPDATE;
                line_op.port  <= pick_port;    // Held as the chosen port until the next pick
                line_op.set   <= pick_set;
                line_op.way   <= pick_req.way;
            end else begin
                line_op.valid <= 1'b0;
            end
            if (state_q == SEQ_LOOKUP) begin
                rsp_state_q <= new_state;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `COH_NUM_L2; i++) begin
            verify_vec[i]        = (state_q == SEQ_RESPOND) &&
                                   (line_op.port == `COH_PORT_WIDTH'(i));
            l2_rsp[i].verify     = verify_vec[i];
            l2_rsp[i].mesi_state = (line_op.port == `COH_PORT_WIDTH'(i)) ?
                                   rsp_state_q : MESI_INVALID;
        end
    end

    verify_one_port: assert property (@(posedge clk) disable iff (reset)
        $onehot0(verify_vec));

    // A port asks for one kind of update at a time
    no_dual_request: assert property (@(posedge clk) disable iff (reset)
        req_both == '0);

    verify_then_release: assert property (@(posedge clk) disable iff (reset)
        |verify_vec |=> state_q == SEQ_RELEASE);

endmodule

`default_nettype wire

// File: rtl/l2_data_shadow.sv
//////////////////////////////////////////////////////////////////////
// L2 data shadow
// Per-port data snapshots by set and way, with the mismatch check
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "coherence_config.svh"

module l2_data_shadow import coherence_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  shadow_wr_t shadow_wr,
    input  line_op_t   line_op,
    output logic       mismatch
);

    logic [`COH_DATA_WIDTH-1:0] snap [`COH_NUM_L2][`COH_NUM_SETS][`COH_NUM_WAYS];
    logic [`COH_DATA_WIDTH-1:0] line_data [`COH_NUM_L2];
    logic                       any_diff;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int p = 0; p < `COH_NUM_L2; p++) begin
                for (int s = 0; s < `COH_NUM_SETS; s++) begin
                    for (int w = 0; w < `COH_NUM_WAYS; w++) begin
                        snap[p][s][w] <= '0;
                    end
                end
            end
        end else if (shadow_wr.valid) begin
            snap[shadow_wr.port][shadow_wr.set][shadow_wr.way] <= shadow_wr.data;
        end
    end

    // Every port's copy of the line under lookup
    always_comb begin
        for (int p = 0; p < `COH_NUM_L2; p++) begin
            line_data[p] = snap[p][line_op.set][line_op.way];
        end
    end

    // Zero means the port holds no copy, so it never counts
    always_comb begin
        any_diff = 1'b0;
        for (int a = 0; a < `COH_NUM_L2 - 1; a++) begin
            for (int b = a + 1; b < `COH_NUM_L2; b++) begin
                if ((|line_data[a]) && (|line_data[b]) &&
                    (line_data[a] != line_data[b])) begin
                    any_diff = 1'b1;
                end
            end
        end
    end

    assign mismatch = line_op.valid && any_diff;

    shadow_set_range: assert property (@(posedge clk) disable iff (reset)
        shadow_wr.valid |-> 32'(shadow_wr.set) < `COH_NUM_SETS);

endmodule

`default_nettype wire

// File: rtl/mesi_directory.sv
//////////////////////////////////////////////////////////////////////
// MESI directory
// One state per set and way, advanced by read and write updates
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "coherence_config.svh"

module mesi_directory import coherence_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  line_op_t    line_op,
    input  logic        mismatch,
    output mesi_state_t new_state
);

    mesi_state_t dir_state [`COH_NUM_SETS][`COH_NUM_WAYS];
    mesi_state_t cur_state;

    assign cur_state = dir_state[line_op.set][line_op.way];

    // Transition rules
    always_comb begin
        if (line_op.op == OP_WRITE_UPDATE) begin
            new_state = MESI_MODIFIED;    // Local write always owns the line
        end else begin
            case (cur_state)
                MESI_INVALID: begin
                    new_state = MESI_EXCLUSIVE;
                end
                MESI_EXCLUSIVE: begin
                    // Differing copies elsewhere mean the line was changed
                    new_state = mismatch ? MESI_MODIFIED : MESI_SHARED;
                end
                MESI_SHARED: begin
                    new_state = MESI_SHARED;
                end
                MESI_MODIFIED: begin
                    new_state = MESI_INVALID;
                end
                default: begin
                    new_state = MESI_INVALID;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < `COH_NUM_SETS; s++) begin
                for (int w = 0; w < `COH_NUM_WAYS; w++) begin
                    dir_state[s][w] <= MESI_INVALID;
                end
            end
        end else if (line_op.valid) begin
            dir_state[line_op.set][line_op.way] <= new_state;
        end
    end

    // One lookup per transaction, so the update never repeats on the next edge
    single_cycle_op: assert property (@(posedge clk) disable iff (reset)
        line_op.valid |=> !line_op.valid);

endmodule

`default_nettype wire

// File: rtl/mesi_coherence_top.sv
//////////////////////////////////////////////////////////////////////
// MESI coherence top
// Sequencer, data shadow and directory for four L2 ports
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "coherence_config.svh"

module mesi_coherence_top import coherence_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  l2_req_t [`COH_NUM_L2-1:0]  l2_req,
    output l2_rsp_t [`COH_NUM_L2-1:0]  l2_rsp
);

    shadow_wr_t  shadow_wr;
    line_op_t    line_op;
    logic        mismatch;
    mesi_state_t new_state;

    // Picks a request and sequences the lookup
    coherence_sequencer sequencer0 (
        .clk       (clk),
        .reset     (reset),
        .l2_req    (l2_req),
        .new_state (new_state),
        .l2_rsp    (l2_rsp),
        .shadow_wr (shadow_wr),
        .line_op   (line_op)
    );

    l2_data_shadow shadow0 (
        .clk       (clk),
        .reset     (reset),
        .shadow_wr (shadow_wr),
        .line_op   (line_op),
        .mismatch  (mismatch)
    );

    // State update one edge after the snapshot write
    mesi_directory directory0 (
        .clk       (clk),
        .reset     (reset),
        .line_op   (line_op),
        .mismatch  (mismatch),
        .new_state (new_state)
    );

endmodule

`default_nettype wire

// File: test/coherence_model.svh
//////////////////////////////////////////////////////////////////////
// Coherence reference model
// Expected MESI states and per-port snapshots, plus the LCG
//////////////////////////////////////////////////////////////////////
`ifndef COHERENCE_MODEL_SVH
`define COHERENCE_MODEL_SVH

mesi_state_t                model_dir  [`COH_NUM_SETS][`COH_NUM_WAYS];
logic [`COH_DATA_WIDTH-1:0] model_snap [`COH_NUM_L2][`COH_NUM_SETS][`COH_NUM_WAYS];
logic [31:0]                lcg_state = 32'd94553;

function automatic void model_reset();
    for (int s = 0; s < `COH_NUM_SETS; s++) begin
        for (int w = 0; w < `COH_NUM_WAYS; w++) begin
            model_dir[s][w] = MESI_INVALID;
            for (int p = 0; p < `COH_NUM_L2; p++) begin
                model_snap[p][s][w] = '0;
            end
        end
    end
endfunction

// Two non-zero copies that differ
function automatic logic model_mismatch(input int set, input int way);
    logic found;
    found = 1'b0;
    for (int a = 0; a < `COH_NUM_L2; a++) begin
        for (int b = a + 1; b < `COH_NUM_L2; b++) begin
            if (model_snap[a][set][way] != '0 && model_snap[b][set][way] != '0 &&
                model_snap[a][set][way] != model_snap[b][set][way]) begin
                found = 1'b1;
            end
        end
    end
    return found;
endfunction

// Snapshot goes in first, the state rule then sees it
function automatic mesi_state_t model_apply(input int port, input logic is_write,
                                            input int set, input int way,
                                            input logic [`COH_DATA_WIDTH-1:0] data);
    mesi_state_t new_st;
    model_snap[port][set][way] = data;
    if (is_write) begin
        new_st = MESI_MODIFIED;
    end else begin
        case (model_dir[set][way])
            MESI_INVALID:   new_st = MESI_EXCLUSIVE;
            MESI_EXCLUSIVE: new_st = model_mismatch(set, way) ? MESI_MODIFIED : MESI_SHARED;
            MESI_SHARED:    new_st = MESI_SHARED;
            default:        new_st = MESI_INVALID;    // Modified drops to Invalid
        endcase
    end
    model_dir[set][way] = new_st;
    return new_st;
endfunction

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

`endif

// File: test/tb_mesi_coherence.sv
//////////////////////////////////////////////////////////////////////
// MESI coherence testbench
// Directed and random L2 requests checked against a reference model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "coherence_config.svh"

module tb_mesi_coherence import coherence_pkg::*; ();

    localparam logic RD = 1'b0;
    localparam logic WR = 1'b1;

    logic                      clk;
    logic                      reset;
    l2_req_t [`COH_NUM_L2-1:0] l2_req;
    l2_rsp_t [`COH_NUM_L2-1:0] l2_rsp;
    int                        errors;
    int                        tests_run;
    int                        tests_failed;

    `include "coherence_model.svh"

    mesi_coherence_top dut0 (
        .clk    (clk),
        .reset  (reset),
        .l2_req (l2_req),
        .l2_rsp (l2_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_state(input int port, input mesi_state_t got, input mesi_state_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED l2_rsp[%0d].mesi_state got %h expected %h", port, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors > start_errors) begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: PASS", name);
        end
    endtask

    // Tag and offset are random, only the set index bits select the line
    task automatic raise_request(input int port, input logic is_write, input int set,
                                 input int way, input logic [31:0] data);
        logic [31:0] salt;
        salt = lcg_next();
        l2_req[port].read_update  = !is_write;
        l2_req[port].write_update = is_write;
        l2_req[port].addr         = {salt[31:10], `COH_INDEX_WIDTH'(set), salt[5:0]};
        l2_req[port].way          = `COH_WAY_WIDTH'(way);
        l2_req[port].data         = data;
    endtask

    task automatic wait_verify(input int port, output mesi_state_t got, output int edges,
                               output logic seen);
        seen  = 1'b0;
        edges = 0;
        got   = MESI_INVALID;
        while (!seen && edges < 50) begin
            @(posedge clk);
            #1;
            edges++;
            for (int i = 0; i < `COH_NUM_L2; i++) begin
                if (i != port && l2_rsp[i].verify !== 1'b0) begin
                    errors++;
                    $display("CHECK FAILED l2_rsp[%0d].verify got %h expected %h",
                             i, l2_rsp[i].verify, 1'b0);
                end
            end
            if (l2_rsp[port].verify === 1'b1) begin
                seen = 1'b1;
                got  = l2_rsp[port].mesi_state;
            end
        end
        if (!seen) begin
            errors++;
            $display("Timed out waiting for verify on port %0d", port);
        end
    endtask

    // Request drops in the cycle after verify
    task automatic finish_request(input int port);
        @(posedge clk);
        #1;
        if (l2_rsp[port].verify !== 1'b0) begin
            errors++;
            $display("CHECK FAILED l2_rsp[%0d].verify got %h expected %h",
                     port, l2_rsp[port].verify, 1'b0);
        end
        l2_req[port] = '0;
    endtask

    task automatic do_request(input int port, input logic is_write, input int set,
                              input int way, input logic [31:0] data,
                              output mesi_state_t got, output int edges);
        mesi_state_t exp;
        logic        seen;
        @(posedge clk);
        #1;
        raise_request(port, is_write, set, way, data);
        exp = model_apply(port, is_write, set, way, data);
        wait_verify(port, got, edges, seen);
        if (seen) begin
            check_state(port, got, exp);
        end
        finish_request(port);
    endtask

    task automatic expect_request(input int port, input logic is_write, input int set,
                                  input int way, input logic [31:0] data,
                                  input mesi_state_t exp);
        mesi_state_t got;
        int          edges;
        do_request(port, is_write, set, way, data, got, edges);
        check_state(port, got, exp);
    endtask

    task automatic test_reset_state();
        int          start;
        mesi_state_t got;
        int          edges;
        start = errors;
        for (int i = 0; i < `COH_NUM_L2; i++) begin
            if (l2_rsp[i].verify !== 1'b0 || l2_rsp[i].mesi_state !== MESI_INVALID) begin
                errors++;
                $display("CHECK FAILED l2_rsp[%0d] got %h expected %h", i, l2_rsp[i], 3'h0);
            end
        end
        do_request(2, RD, 5, 2, 32'h0000_0011, got, edges);
        check_state(2, got, MESI_EXCLUSIVE);
        if (edges != 2) begin    // Acceptance edge plus the lookup edge
            errors++;
            $display("Verify came %0d edges after the request instead of 2", edges);
        end
        expect_request(0, RD, 0, 0, 32'h0000_0022, MESI_EXCLUSIVE);
        end_test("reset_state", start);
    endtask

    task automatic test_shared_path();
        int start;
        start = errors;
        expect_request(0, RD, 1, 3, 32'hCAFE_0001, MESI_EXCLUSIVE);
        expect_request(1, RD, 1, 3, 32'hCAFE_0001, MESI_SHARED);
        expect_request(0, RD, 1, 3, 32'hCAFE_0001, MESI_SHARED);
        // Port 3 holds zero, so port 1's copy is not contested
        expect_request(3, RD, 2, 0, 32'h0000_0000, MESI_EXCLUSIVE);
        expect_request(1, RD, 2, 0, 32'h0000_BEEF, MESI_SHARED);
        end_test("shared_path", start);
    endtask

    task automatic test_mismatch_path();
        int start;
        start = errors;
        expect_request(0, RD, 3, 1, 32'h0000_1111, MESI_EXCLUSIVE);
        expect_request(2, RD, 3, 1, 32'h0000_2222, MESI_MODIFIED);
        expect_request(0, RD, 3, 1, 32'h0000_1111, MESI_INVALID);
        end_test("mismatch_path", start);
    endtask

    task automatic test_write_update();
        int start;
        start = errors;
        expect_request(2, WR, 1, 3, 32'hCAFE_0002, MESI_MODIFIED);    // From Shared
        expect_request(1, RD, 1, 3, 32'hCAFE_0002, MESI_INVALID);
        expect_request(3, WR, 3, 1, 32'h0000_3333, MESI_MODIFIED);    // From Invalid
        expect_request(3, RD, 3, 1, 32'h0000_3333, MESI_INVALID);
        expect_request(0, WR, 5, 2, 32'h0000_0044, MESI_MODIFIED);    // From Exclusive
        expect_request(0, WR, 5, 2, 32'h0000_0055, MESI_MODIFIED);
        expect_request(2, RD, 5, 2, 32'h0000_0055, MESI_INVALID);
        end_test("write_update", start);
    endtask

    task automatic test_priority();
        int          start;
        mesi_state_t exp1;
        mesi_state_t exp3;
        mesi_state_t got;
        int          edges;
        logic        seen;
        start = errors;
        @(posedge clk);
        #1;
        raise_request(3, RD, 6, 1, 32'h0000_0077);
        raise_request(1, RD, 6, 1, 32'h0000_0077);
        exp1 = model_apply(1, RD, 6, 1, 32'h0000_0077);
        exp3 = model_apply(3, RD, 6, 1, 32'h0000_0077);
        wait_verify(1, got, edges, seen);
        check_state(1, got, exp1);
        check_state(1, got, MESI_EXCLUSIVE);
        finish_request(1);
        // Port 3 has held its request through port 1's transaction
        wait_verify(3, got, edges, seen);
        check_state(3, got, exp3);
        check_state(3, got, MESI_SHARED);
        finish_request(3);
        end_test("priority", start);
    endtask

    task automatic test_random_traffic();
        int          start;
        logic [31:0] r;
        mesi_state_t got;
        int          edges;
        start = errors;
        for (int n = 0; n < 300; n++) begin
            r = lcg_next();
            // Few sets and data values, so lines get shared and contested often
            do_request(int'(r[17:16]), r[20] & r[21], int'(r[25:24]), int'(r[29:28]),
                       32'(r[31:30]) * 32'h1111_1111, got, edges);
        end
        end_test("random_traffic", start);
    endtask

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        l2_req       = '0;
        model_reset();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_shared_path();
        test_mismatch_path();
        test_write_update();
        test_priority();
        test_random_traffic();

        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mesi_coherence.f
+incdir+rtl
+incdir+test
rtl/coherence_pkg.sv
rtl/coherence_sequencer.sv
rtl/l2_data_shadow.sv
rtl/mesi_directory.sv
rtl/mesi_coherence_top.sv
test/tb_mesi_coherence.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mesi_coherence
FILELIST  = mesi_coherence.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, whatever the simulator's exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
